//--- ifu_top.f
+incdir+hw
hw/ifu_pkg.sv
hw/branch_predecode.sv
hw/icache.sv
hw/fetch_unit.sv
hw/ifu_top.sv
test/ifu_assertions.sv
test/ifu_tb.sv

//--- Bender.yml
package:
  name: ifu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/ifu_pkg.sv
      - hw/branch_predecode.sv
      - hw/icache.sv
      - hw/fetch_unit.sv
      - hw/ifu_top.sv
  - target: test
    files:
      - test/ifu_assertions.sv
      - test/ifu_tb.sv

//--- test/ifu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

	localparam logic [63:0] RESET_PC = 64'h0000_0000_8000_0000;
	localparam int          LIMIT    = 200;

	logic           clk = 1'b0;
	logic           rst;
	logic           if_ready;
	logic           redirect;
	ifu_pkg::addr_t redirect_pc;
	logic           mem_rvalid = 1'b0;
	ifu_pkg::line_t mem_rdata  = '0;
	logic           inv;
	ifu_pkg::addr_t inv_addr;

	wire                 if_valid;
	wire ifu_pkg::addr_t if_pc;
	wire ifu_pkg::inst_t if_inst;
	wire                 if_pred_taken;
	wire                 mem_req;
	wire ifu_pkg::addr_t mem_addr;

	// sparse program store keyed by word address
	ifu_pkg::inst_t prog [logic [61:0]];

	// refill responder state
	logic           pend       = 1'b0;
	logic [1:0]     wait_cnt   = '0;
	ifu_pkg::addr_t req_addr   = '0;
	logic [31:0]    mem_rng    = 32'h5f4f41b7;
	ifu_pkg::addr_t watch_line = '0;
	int             watch_reqs = 0;

	logic [31:0] bp_rng;
	int          checks = 0;
	int          errors = 0;

	always #4 clk = ~clk;

	ifu_top u_ifu_top (
		.clk           (clk),
		.rst           (rst),
		.if_valid      (if_valid),
		.if_ready      (if_ready),
		.if_pc         (if_pc),
		.if_inst       (if_inst),
		.if_pred_taken (if_pred_taken),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.mem_req       (mem_req),
		.mem_addr      (mem_addr),
		.mem_rvalid    (mem_rvalid),
		.mem_rdata     (mem_rdata),
		.inv           (inv),
		.inv_addr      (inv_addr)
	);

	// **********************************************************************
	// memory model
	// **********************************************************************

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// addi with address-folded bits so it never transfers control
	function automatic ifu_pkg::inst_t fill_word(input ifu_pkg::addr_t a);
		return {a[26:2] ^ a[51:27] ^ {a[63:52], 13'd0}, 7'b0010011};
	endfunction

	function automatic ifu_pkg::inst_t mem_word(input ifu_pkg::addr_t a);
		if (prog.exists(a[63:2])) begin
			return prog[a[63:2]];
		end else begin
			return fill_word(a);
		end
	endfunction

	function automatic void store_word(input ifu_pkg::addr_t a, input ifu_pkg::inst_t w);
		prog[a[63:2]] = w;
	endfunction

	// one beat per request, 1 to 4 cycles after mem_req
	always @(posedge clk) begin
		mem_rvalid <= 1'b0;
		if (pend) begin
			if (wait_cnt == 2'd0) begin
				mem_rvalid <= 1'b1;
				mem_rdata  <= {mem_word(req_addr + 64'd4), mem_word(req_addr)};
				pend       <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
		if (mem_req) begin
			mem_rng = xorshift(mem_rng);
			if (mem_rng[1:0] == 2'd0) begin
				// shortest latency answers in the very next cycle
				mem_rvalid <= 1'b1;
				mem_rdata  <= {mem_word(mem_addr + 64'd4), mem_word(mem_addr)};
			end else begin
				pend     <= 1'b1;
				req_addr <= mem_addr;
				wait_cnt <= mem_rng[1:0] - 2'd1;
			end
			// requests seen for the line under watch
			if (mem_addr == watch_line) begin
				watch_reqs <= watch_reqs + 1;
			end
		end
	end

	// **********************************************************************
	// encoders and checking helpers
	// **********************************************************************

	// jal x1 with a byte offset
	function automatic ifu_pkg::inst_t jal_word(input logic [63:0] off);
		return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
	endfunction

	// branch on x1, x2 with funct3 and a byte offset
	function automatic ifu_pkg::inst_t branch_word(input logic [2:0] f3, input logic [63:0] off);
		return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic finish_run;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		errors++;
		finish_run();
	endtask

	// sel 0 waits for a transfer, 1 for if_valid and anything else for mem_req
	function automatic logic condition_met(input int sel);
		case (sel)
			0: return if_valid && if_ready;
			1: return if_valid;
			default: return mem_req;
		endcase
	endfunction

	// returns on the edge where the condition is sampled true
	task automatic wait_until(input int sel, input string what);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!condition_met(sel) && n < LIMIT);
		if (!condition_met(sel)) begin
			abort_run({"timeout while waiting for ", what});
		end
	endtask

	task automatic expect_xfer(input string name, input ifu_pkg::addr_t pc,
			input ifu_pkg::inst_t word, input logic taken);
		wait_until(0, "an instruction transfer");
		check({name, " pc"}, pc, if_pc);
		check({name, " inst"}, word, if_inst);
		check({name, " taken"}, taken, if_pred_taken);
	endtask

	// one-cycle redirect whose flush cycle must offer nothing
	task automatic jump_to(input ifu_pkg::addr_t pc);
		redirect    <= 1'b1;
		redirect_pc <= pc;
		@(posedge clk);
		check("redirect flush", 0, if_valid);
		redirect    <= 1'b0;
	endtask

	// **********************************************************************
	// directed tests
	// **********************************************************************

	task automatic straight_line;
		ifu_pkg::addr_t pc;
		pc = RESET_PC;
		repeat (8) begin
			expect_xfer("straight", pc, mem_word(pc), 1'b0);
			pc = pc + 64'd4;
		end
	endtask

	task automatic jal_targets;
		ifu_pkg::addr_t base;
		base = 64'h8000_1000;
		store_word(base, jal_word(64'd16));
		store_word(base + 64'd16, jal_word(-64'd8));
		jump_to(base);
		expect_xfer("jal fwd", base, mem_word(base), 1'b1);
		expect_xfer("jal back", base + 64'd16, mem_word(base + 64'd16), 1'b1);
		// pc + 16 - 8
		expect_xfer("jal back target", base + 64'd8, mem_word(base + 64'd8), 1'b0);
	endtask

	task automatic cond_branches;
		ifu_pkg::addr_t base;
		base = 64'h8000_2000;
		// forward bne, then backward beq
		store_word(base + 64'd4, branch_word(3'b001, 64'd12));
		store_word(base + 64'd8, branch_word(3'b000, -64'd8));
		jump_to(base);
		expect_xfer("cond start", base, mem_word(base), 1'b0);
		expect_xfer("bne fwd", base + 64'd4, mem_word(base + 64'd4), 1'b0);
		expect_xfer("beq back", base + 64'd8, mem_word(base + 64'd8), 1'b1);
		expect_xfer("beq target", base, mem_word(base), 1'b0);
	endtask

	task automatic back_pressure;
		ifu_pkg::addr_t pc;
		ifu_pkg::addr_t held_pc;
		ifu_pkg::inst_t held_inst;
		int             stall;
		pc = 64'h8000_3000;
		if_ready <= 1'b0;
		jump_to(pc);
		repeat (8) begin
			if_ready <= 1'b0;
			wait_until(1, "if_valid under back-pressure");
			held_pc   = if_pc;
			held_inst = if_inst;
			bp_rng = xorshift(bp_rng);
			stall  = 1 + bp_rng % 5;
			repeat (stall) begin
				@(posedge clk);
				check("stall valid", 1, if_valid);
				check("stall pc", held_pc, if_pc);
				check("stall inst", held_inst, if_inst);
			end
			if_ready <= 1'b1;
			// exactly the next word with none skipped or doubled
			expect_xfer("released", pc, mem_word(pc), 1'b0);
			pc = pc + 64'd4;
		end
	endtask

	task automatic redirects;
		ifu_pkg::addr_t hot;
		ifu_pkg::addr_t cold;
		ifu_pkg::addr_t far;
		int             base;
		hot  = 64'h8000_3000;
		cold = 64'h8000_4040;
		far  = 64'h8000_5080;
		watch_line <= cold;
		base = watch_reqs;
		jump_to(hot);
		expect_xfer("redirect hit", hot, mem_word(hot), 1'b0);
		// leave while the cold refill is out
		jump_to(cold);
		wait_until(2, "mem_req after a redirect");
		check("miss addr", cold, mem_addr);
		jump_to(far);
		expect_xfer("redirect miss", far, mem_word(far), 1'b0);
		// abandoned refill still filled its line
		jump_to(cold);
		expect_xfer("refilled line", cold, mem_word(cold), 1'b0);
		check("refill count", base + 1, watch_reqs);
	endtask

	task automatic invalidate;
		ifu_pkg::addr_t tgt;
		ifu_pkg::inst_t fresh;
		int             base;
		tgt   = 64'h8000_3008;
		fresh = 32'h5a50_8093;
		jump_to(tgt);
		expect_xfer("inv old word", tgt, mem_word(tgt), 1'b0);
		if_ready   <= 1'b0;
		watch_line <= tgt & ~64'd7;
		base = watch_reqs;
		// rewrite memory before telling the cache
		store_word(tgt, fresh);
		inv      <= 1'b1;
		inv_addr <= tgt;
		@(posedge clk);
		inv <= 1'b0;
		jump_to(tgt);
		if_ready <= 1'b1;
		expect_xfer("inv new word", tgt, fresh, 1'b0);
		check("inv refill seen", 1, watch_reqs > base);
	endtask

	// **********************************************************************
	// main sequence
	// **********************************************************************

	initial begin
		rst         = 1'b1;
		if_ready    = 1'b1;
		redirect    = 1'b0;
		redirect_pc = '0;
		inv         = 1'b0;
		inv_addr    = '0;
		bp_rng      = 32'h5f4f41b7;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		// empty cache and reset pc with nothing offered
		check("reset valid", 0, if_valid);
		check("reset mem_req", 0, mem_req);
		check("reset pc", RESET_PC, if_pc);
		straight_line();
		jal_targets();
		cond_branches();
		back_pressure();
		redirects();
		invalidate();
		finish_run();
	end

endmodule

`default_nettype wire

//--- test/ifu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_assertions (
	input wire                 clk,
	input wire                 rst,
	input wire                 req,
	input wire                 rvalid,
	input wire                 valid,
	input wire                 ready,
	input wire                 flush,
	input wire ifu_pkg::addr_t pc,
	input wire ifu_pkg::inst_t word
);

	// request sent, answer not back yet
	logic outstanding;

	always_ff @(posedge clk) begin
		if (rst) begin
			outstanding <= 1'b0;
		end else if (req) begin
			outstanding <= 1'b1;
		end else if (rvalid) begin
			outstanding <= 1'b0;
		end
	end

	// **********************************************************************
	// memory port
	// **********************************************************************

	// strobe, never a level
	req_single: assert property (@(posedge clk) disable iff (rst) req |=> !req)
		else $error("mem_req stayed high for more than one cycle");

	// one refill at a time
	req_in_flight: assert property (@(posedge clk) disable iff (rst) outstanding |-> !req)
		else $error("second mem_req raised before mem_rvalid");

	// **********************************************************************
	// decode handshake
	// **********************************************************************

	// offered instruction is frozen until taken
	hold_stable: assert property (@(posedge clk) disable iff (rst)
		valid && !ready |=> $stable(pc) && $stable(word))
		else $error("if_pc or if_inst changed under back-pressure");

	// flush cycle offers nothing
	flush_no_valid: assert property (@(posedge clk) disable iff (rst) flush |-> !valid)
		else $error("if_valid high in a redirect cycle");

endmodule

// handshake side, memory inputs tied off
bind fetch_unit ifu_assertions u_fetch_assert (
	.clk    (clk),
	.rst    (rst),
	.req    (1'b0),
	.rvalid (1'b0),
	.valid  (if_valid),
	.ready  (if_ready),
	.flush  (redirect),
	.pc     (fetch_pc),
	.word   (inst)
);

// refill side, handshake inputs tied off
bind icache ifu_assertions u_icache_assert (
	.clk    (clk),
	.rst    (rst),
	.req    (mem_req),
	.rvalid (mem_rvalid),
	.valid  (1'b0),
	.ready  (1'b1),
	.flush  (1'b0),
	.pc     (fetch_pc),
	.word   (inst)
);

`default_nettype wire

//--- hw/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
	input  wire                 clk,
	input  wire                 rst,
	output wire                 if_valid,
	input  wire                 if_ready,
	output wire ifu_pkg::addr_t if_pc,
	output wire ifu_pkg::inst_t if_inst,
	output wire                 if_pred_taken,
	input  wire                 redirect,
	input  wire ifu_pkg::addr_t redirect_pc,
	output wire                 mem_req,
	output wire ifu_pkg::addr_t mem_addr,
	input  wire                 mem_rvalid,
	input  wire ifu_pkg::line_t mem_rdata,
	input  wire                 inv,
	input  wire ifu_pkg::addr_t inv_addr
);

	// **********************************************************************
	// internal nets
	// **********************************************************************

	wire ifu_pkg::addr_t fetch_pc;
	wire                 hit;
	wire ifu_pkg::inst_t inst;
	wire                 pred_taken;
	wire ifu_pkg::addr_t pred_target;

	// decode sees the fetch pc, the selected word and its prediction
	assign if_pc         = fetch_pc;
	assign if_inst       = inst;
	assign if_pred_taken = pred_taken;

	// pc and handshake
	fetch_unit u_fetch_unit (
		.clk         (clk),
		.rst         (rst),
		.hit         (hit),
		.inst        (inst),
		.pred_taken  (pred_taken),
		.pred_target (pred_target),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.if_ready    (if_ready),
		.if_valid    (if_valid),
		.fetch_pc    (fetch_pc)
	);

	// static prediction on the fetched word
	branch_predecode u_branch_predecode (
		.fetch_pc    (fetch_pc),
		.inst        (inst),
		.pred_taken  (pred_taken),
		.pred_target (pred_target)
	);

	// instruction cache with memory refill port
	icache u_icache (
		.clk        (clk),
		.rst        (rst),
		.fetch_pc   (fetch_pc),
		.hit        (hit),
		.inst       (inst),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.inv        (inv),
		.inv_addr   (inv_addr)
	);

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_config.svh"

module fetch_unit (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 hit,
	input  wire ifu_pkg::inst_t inst,
	input  wire                 pred_taken,
	input  wire ifu_pkg::addr_t pred_target,
	input  wire                 redirect,
	input  wire ifu_pkg::addr_t redirect_pc,
	input  wire                 if_ready,
	output logic                if_valid,
	output ifu_pkg::addr_t      fetch_pc
);

	ifu_pkg::addr_t pc_q;
	ifu_pkg::addr_t pc_d;
	ifu_pkg::addr_t seq_pc;
	logic           xfer;

	// **********************************************************************
	// handshake toward decode
	// **********************************************************************

	// instruction is ready as soon as the lookup hits
	// redirect flushes whatever sits here this cycle
	assign if_valid = hit && !redirect;

	// one instruction leaves per valid && ready
	assign xfer = if_valid && if_ready;

	// **********************************************************************
	// next pc
	// **********************************************************************

	assign seq_pc = pc_q + 64'd4;

	always_comb begin
		// hold by default on a miss or under back-pressure
		pc_d = pc_q;
		if (redirect) begin
			// later stage wins over everything
			pc_d = redirect_pc;
		end else if (xfer) begin
			if (pred_taken) begin
				pc_d = pred_target;
			end else begin
				pc_d = seq_pc;
			end
		end
	end

	// **********************************************************************
	// pc register
	// **********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= `IFU_RESET_PC;
		end else begin
			pc_q <= pc_d;
		end
	end

	// same pc feeds the cache, the predecoder and decode
	assign fetch_pc = pc_q;

endmodule

`default_nettype wire

//--- hw/icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_config.svh"

module icache (
	input  wire                 clk,
	input  wire                 rst,
	input  wire ifu_pkg::addr_t fetch_pc,
	output logic                hit,
	output ifu_pkg::inst_t      inst,
	output logic                mem_req,
	output ifu_pkg::addr_t      mem_addr,
	input  wire                 mem_rvalid,
	input  wire ifu_pkg::line_t mem_rdata,
	input  wire                 inv,
	input  wire ifu_pkg::addr_t inv_addr
);

	// storage
	logic [`IFU_LINES-1:0] valid_q;
	ifu_pkg::tag_t         tag_q  [`IFU_LINES];
	ifu_pkg::line_t        data_q [`IFU_LINES];

	// address fields
	ifu_pkg::index_t fetch_idx;
	ifu_pkg::tag_t   fetch_tag;
	ifu_pkg::index_t inv_idx;
	ifu_pkg::tag_t   inv_tag;
	ifu_pkg::index_t miss_idx;
	ifu_pkg::tag_t   miss_tag;

	ifu_pkg::line_t fetch_line;
	logic           inv_match;
	logic           refill;

	// refill control
	ifu_pkg::cache_state_e state_q;
	ifu_pkg::cache_state_e state_d;
	ifu_pkg::addr_t        miss_addr_q;

	// **********************************************************************
	// lookup
	// **********************************************************************

	assign fetch_idx = fetch_pc[`IFU_OFFSET_W +: `IFU_INDEX_W];
	assign fetch_tag = fetch_pc[63 -: `IFU_TAG_W];

	assign fetch_line = data_q[fetch_idx];
	assign hit        = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);

	// pc bit 2 picks the upper or lower word
	assign inst = fetch_pc[2] ? fetch_line[63:32] : fetch_line[31:0];

	// **********************************************************************
	// refill fsm
	// **********************************************************************

	always_comb begin
		state_d = state_q;
		case (state_q)
			// a miss seen here issues the request next cycle
			ifu_pkg::IDLE: if (!hit) state_d = ifu_pkg::REQ;
			// request is a single-cycle strobe
			ifu_pkg::REQ: state_d = ifu_pkg::WAIT;
			// wait for the one-beat answer
			ifu_pkg::WAIT: if (mem_rvalid) state_d = ifu_pkg::IDLE;
			default: state_d = ifu_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ifu_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// line address of the miss, kept for the whole refill
	always_ff @(posedge clk) begin
		if ((state_q == ifu_pkg::IDLE) && !hit) begin
			miss_addr_q <= {fetch_pc[63:`IFU_OFFSET_W], {`IFU_OFFSET_W{1'b0}}};
		end
	end

	assign mem_req  = (state_q == ifu_pkg::REQ);
	assign mem_addr = miss_addr_q;

	// refill always lands in the latched line, even after a redirect
	assign miss_idx = miss_addr_q[`IFU_OFFSET_W +: `IFU_INDEX_W];
	assign miss_tag = miss_addr_q[63 -: `IFU_TAG_W];
	assign refill   = (state_q == ifu_pkg::WAIT) && mem_rvalid;

	// **********************************************************************
	// array update
	// **********************************************************************

	// invalidate only a line that really holds inv_addr
	assign inv_idx   = inv_addr[`IFU_OFFSET_W +: `IFU_INDEX_W];
	assign inv_tag   = inv_addr[63 -: `IFU_TAG_W];
	assign inv_match = inv && valid_q[inv_idx] && (tag_q[inv_idx] == inv_tag);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			if (inv_match) begin
				valid_q[inv_idx] <= 1'b0;
			end
			// refill comes last so it is kept when both hit one line
			if (refill) begin
				valid_q[miss_idx] <= 1'b1;
			end
		end
	end

	// tag and data written together with the valid bit
	always_ff @(posedge clk) begin
		if (refill) begin
			tag_q[miss_idx]  <= miss_tag;
			data_q[miss_idx] <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

//--- hw/branch_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predecode (
	input  wire ifu_pkg::addr_t fetch_pc,
	input  wire ifu_pkg::inst_t inst,
	output logic                pred_taken,
	output ifu_pkg::addr_t      pred_target
);

	ifu_pkg::br_kind_e kind;
	ifu_pkg::imm_t     imm_b;
	ifu_pkg::imm_t     imm_j;

	// **********************************************************************
	// classify
	// **********************************************************************

	always_comb begin
		kind = ifu_pkg::NONE;
		if (inst[6:0] == 7'b1101111) begin
			// jal
			kind = ifu_pkg::JAL;
		end else if (inst[6:0] == 7'b1100011) begin
			// branch opcode, funct3 010 and 011 are reserved
			case (inst[14:12])
				3'b000: kind = ifu_pkg::COND;  // beq
				3'b001: kind = ifu_pkg::COND;  // bne
				3'b100: kind = ifu_pkg::COND;  // blt
				3'b101: kind = ifu_pkg::COND;  // bge
				3'b110: kind = ifu_pkg::COND;  // bltu
				3'b111: kind = ifu_pkg::COND;  // bgeu
				default: kind = ifu_pkg::NONE;
			endcase
		end
	end

	// **********************************************************************
	// immediates
	// **********************************************************************

	// b-type, 13 bit offset
	assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	// j-type, 21 bit offset
	assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// **********************************************************************
	// static prediction
	// **********************************************************************

	// jal always, branches only backward
	assign pred_taken = (kind == ifu_pkg::JAL) ||
	                    ((kind == ifu_pkg::COND) && inst[31]);

	// target relative to the instruction's own pc
	assign pred_target = fetch_pc + ((kind == ifu_pkg::JAL) ? imm_j : imm_b);

endmodule

`default_nettype wire

//--- hw/ifu_pkg.sv
`default_nettype none

`include "ifu_config.svh"

package ifu_pkg;

	// **********************************************************************
	// datapath widths
	// **********************************************************************

	// byte address
	typedef logic [63:0] addr_t;
	// one rv instruction
	typedef logic [31:0] inst_t;
	// cache line, two instructions
	typedef logic [63:0] line_t;
	// sign-extended branch offset
	typedef logic [63:0] imm_t;

	// address split for the icache
	typedef logic [`IFU_TAG_W-1:0]   tag_t;
	typedef logic [`IFU_INDEX_W-1:0] index_t;

	// **********************************************************************
	// state and class encodings
	// **********************************************************************

	// icache refill controller
	typedef enum logic [1:0] {IDLE, REQ, WAIT} cache_state_e;

	// predecode result
	typedef enum logic [1:0] {NONE, COND, JAL} br_kind_e;

endpackage

`default_nettype wire

//--- hw/ifu_config.svh
`ifndef IFU_CONFIG_SVH
`define IFU_CONFIG_SVH

// **********************************************************************
// fetch stage configuration
// **********************************************************************

// pc value after reset, start of dram
`define IFU_RESET_PC 64'h0000_0000_8000_0000

// number of icache lines
`define IFU_LINES 16

// line index width, log2 of IFU_LINES
`define IFU_INDEX_W 4

// byte offset inside a 64-bit line
`define IFU_OFFSET_W 3

// tag is whatever is left above index and offset
`define IFU_TAG_W (64 - `IFU_OFFSET_W - `IFU_INDEX_W)

`endif
